// ==== design/pwo_consts.svh ====
// Modulus and size macros of the pointwise unit that the RTL and the testbench include
`ifndef PWO_CONSTS_SVH
`define PWO_CONSTS_SVH

// Modulus q = 2^23 - 2^13 + 1
`define PWO_Q           23'd8380417

// Coefficient width and lane width with one zero pad bit on top
`define PWO_COEFF_W     23
`define PWO_LANE_W      24

// Four coefficients per memory word and 64 words per polynomial
`define PWO_LANES       4
`define PWO_WORDS       64
`define PWO_IDX_W       6

// Memory word address
`define PWO_ADDR_W      15

`endif

// ==== design/pwo_pkg.sv ====
// Shared types of the pointwise unit referenced by scoped names from RTL and testbench
`default_nettype none
`include "pwo_consts.svh"

package pwo_pkg;

    // Pointwise operation
    typedef enum logic [1:0] {
        pwm = 2'd0,
        pwa = 2'd1,
        pws = 2'd2
    } pwo_mode_e;

    // Command latched at start
    typedef struct packed {
        pwo_mode_e mode;
        logic      accumulate;
    } pwo_cmd_t;

    // ====================
    // Memory interface
    // ====================

    typedef enum logic [1:0] {
        rw_idle  = 2'd0,
        rw_read  = 2'd1,
        rw_write = 2'd2
    } rw_cmd_e;

    typedef struct packed {
        rw_cmd_e                 rd_wr_en;
        logic [`PWO_ADDR_W-1:0]  addr;
    } mem_req_t;

    // Polynomial base addresses
    typedef struct packed {
        logic [`PWO_ADDR_W-1:0]  a;
        logic [`PWO_ADDR_W-1:0]  b;
        logic [`PWO_ADDR_W-1:0]  c;
    } base_addr_t;

    // ====================
    // Data words
    // ====================

    typedef struct packed {
        logic                    pad;
        logic [`PWO_COEFF_W-1:0] coeff;
    } lane_t;

    // Lane 0 sits in the low bits
    typedef lane_t [`PWO_LANES-1:0] coeff_word_t;

endpackage

`default_nettype wire

// ==== design/pwo_sequencer.sv ====
// Issue stage of the pointwise unit that takes start, walks the 64 words and issues the reads
`timescale 1ns/1ns
`default_nettype none
`include "pwo_consts.svh"

module pwo_sequencer (
    input  wire                       clk,
    input  wire                       reset_n,
    input  wire                       start_i,
    input  wire pwo_pkg::pwo_cmd_t    cmd_i,
    input  wire pwo_pkg::base_addr_t  base_i,
    output pwo_pkg::mem_req_t         a_rd_req_o,
    output pwo_pkg::mem_req_t         b_rd_req_o,
    output pwo_pkg::mem_req_t         c_rd_req_o,
    output pwo_pkg::pwo_cmd_t         cmd_o,
    output logic                      data_valid_o,
    output logic [`PWO_IDX_W-1:0]     data_idx_o,
    output logic                      busy_o,
    output logic                      done_o
);

    localparam logic [`PWO_IDX_W-1:0] last_idx = `PWO_IDX_W'(`PWO_WORDS - 1);

    pwo_pkg::pwo_cmd_t         cmd_q;
    logic                      issue_q;
    logic [`PWO_IDX_W-1:0]     idx_q;
    logic [1:0]                drain_q;
    logic                      data_valid_q;
    logic [`PWO_IDX_W-1:0]     data_idx_q;
    logic [`PWO_ADDR_W-1:0]    idx_ext;
    logic                      c_rd_en;

    // Busy covers the 64 issue cycles plus two drain cycles for ALU and write
    assign busy_o = issue_q || (drain_q != 2'd0);
    assign done_o = (drain_q == 2'd1);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cmd_q        <= '0;
            issue_q      <= 1'b0;
            idx_q        <= '0;
            drain_q      <= 2'd0;
            data_valid_q <= 1'b0;
            data_idx_q   <= '0;
        end else begin
            // Line up valid and index with the one-cycle memory latency
            data_valid_q <= issue_q;
            data_idx_q   <= idx_q;
            if (start_i && !busy_o) begin
                cmd_q   <= cmd_i;
                issue_q <= 1'b1;
                idx_q   <= '0;
            end else if (issue_q) begin
                idx_q <= idx_q + 1'b1;
                if (idx_q == last_idx) begin
                    issue_q <= 1'b0;
                    drain_q <= 2'd2;
                end
            end else if (drain_q != 2'd0) begin
                drain_q <= drain_q - 2'd1;
            end
        end
    end

    // ====================
    // Read requests
    // ====================

    assign idx_ext = {{(`PWO_ADDR_W - `PWO_IDX_W){1'b0}}, idx_q};

    // Accumulate source is only fetched for pwm
    assign c_rd_en = issue_q && (cmd_q.mode == pwo_pkg::pwm) && cmd_q.accumulate;

    assign a_rd_req_o.rd_wr_en = issue_q ? pwo_pkg::rw_read : pwo_pkg::rw_idle;
    assign a_rd_req_o.addr     = issue_q ? base_i.a + idx_ext : '0;
    assign b_rd_req_o.rd_wr_en = issue_q ? pwo_pkg::rw_read : pwo_pkg::rw_idle;
    assign b_rd_req_o.addr     = issue_q ? base_i.b + idx_ext : '0;
    assign c_rd_req_o.rd_wr_en = c_rd_en ? pwo_pkg::rw_read : pwo_pkg::rw_idle;
    assign c_rd_req_o.addr     = c_rd_en ? base_i.c + idx_ext : '0;

    assign cmd_o        = cmd_q;
    assign data_valid_o = data_valid_q;
    assign data_idx_o   = data_idx_q;

endmodule

`default_nettype wire

// ==== design/pwo_lane_alu.sv ====
// Execute stage of the pointwise unit with four lanes of modular multiply, add or subtract
`timescale 1ns/1ns
`default_nettype none
`include "pwo_consts.svh"

module pwo_lane_alu (
    input  wire                        clk,
    input  wire                        reset_n,
    input  wire pwo_pkg::pwo_cmd_t     cmd_i,
    input  wire                        valid_i,
    input  wire [`PWO_IDX_W-1:0]       idx_i,
    input  wire pwo_pkg::coeff_word_t  a_i,
    input  wire pwo_pkg::coeff_word_t  b_i,
    input  wire pwo_pkg::coeff_word_t  c_i,
    output pwo_pkg::coeff_word_t       res_o,
    output logic                       valid_o,
    output logic [`PWO_IDX_W-1:0]      idx_o
);

    pwo_pkg::coeff_word_t       res_d;
    pwo_pkg::coeff_word_t       res_q;
    logic                       valid_q;
    logic [`PWO_IDX_W-1:0]      idx_q;

    // One lane with operands already below q
    function automatic logic [`PWO_COEFF_W-1:0] lane_op(
        input pwo_pkg::pwo_cmd_t       cmd,
        input logic [`PWO_COEFF_W-1:0] a,
        input logic [`PWO_COEFF_W-1:0] b,
        input logic [`PWO_COEFF_W-1:0] c
    );
        logic [2*`PWO_COEFF_W:0] wide;
        logic [2*`PWO_COEFF_W:0] rem;
        logic [`PWO_COEFF_W:0]   sum;
        logic [`PWO_COEFF_W-1:0] res;
        wide = {{(`PWO_COEFF_W + 1){1'b0}}, a} * {{(`PWO_COEFF_W + 1){1'b0}}, b};
        if (cmd.accumulate) begin
            wide = wide + {{(`PWO_COEFF_W + 1){1'b0}}, c};
        end
        rem = wide % `PWO_Q;
        sum = {1'b0, a} + {1'b0, b};
        case (cmd.mode)
            pwo_pkg::pwm: res = rem[`PWO_COEFF_W-1:0];
            pwo_pkg::pwa: res = (sum >= {1'b0, `PWO_Q}) ? sum[`PWO_COEFF_W-1:0] - `PWO_Q
                                                      : sum[`PWO_COEFF_W-1:0];
            // Borrow wraps back into range by adding q
            pwo_pkg::pws: res = (a >= b) ? a - b : a + (`PWO_Q - b);
            default:      res = '0;
        endcase
        return res;
    endfunction

    always_comb begin
        for (int i = 0; i < `PWO_LANES; i++) begin
            res_d[i].pad   = 1'b0;
            res_d[i].coeff = lane_op(cmd_i, a_i[i].coeff, b_i[i].coeff, c_i[i].coeff);
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (valid_i) begin
            res_q <= res_d;
            idx_q <= idx_i;
        end
    end

    assign res_o   = res_q;
    assign valid_o = valid_q;
    assign idx_o   = idx_q;

endmodule

`default_nettype wire

// ==== design/pwo_writeback.sv ====
// Result stage of the pointwise unit that turns an ALU result into the write request to c
`timescale 1ns/1ns
`default_nettype none
`include "pwo_consts.svh"

module pwo_writeback (
    input  wire [`PWO_ADDR_W-1:0]      base_c_i,
    input  wire                        valid_i,
    input  wire [`PWO_IDX_W-1:0]       idx_i,
    input  wire pwo_pkg::coeff_word_t  res_i,
    output pwo_pkg::mem_req_t          c_wr_req_o,
    output pwo_pkg::coeff_word_t       c_wr_data_o
);

    logic [`PWO_ADDR_W-1:0] wr_addr;

    // Destination word in c
    assign wr_addr = base_c_i + {{(`PWO_ADDR_W - `PWO_IDX_W){1'b0}}, idx_i};

    // Address and data stay at zero between results
    always_comb begin
        if (valid_i) begin
            c_wr_req_o.rd_wr_en = pwo_pkg::rw_write;
            c_wr_req_o.addr     = wr_addr;
            c_wr_data_o         = res_i;
        end else begin
            c_wr_req_o.rd_wr_en = pwo_pkg::rw_idle;
            c_wr_req_o.addr     = '0;
            c_wr_data_o         = '0;
        end
    end

endmodule

`default_nettype wire

// ==== design/pwo_top.sv ====
// Top level of the pointwise unit joining the three stages to the memory ports
`timescale 1ns/1ns
`default_nettype none
`include "pwo_consts.svh"

module pwo_top (
    input  wire                        clk,
    input  wire                        reset_n,
    input  wire                        start_i,
    input  wire pwo_pkg::pwo_cmd_t     cmd_i,
    input  wire pwo_pkg::base_addr_t   base_i,
    input  wire pwo_pkg::coeff_word_t  a_rd_data_i,
    input  wire pwo_pkg::coeff_word_t  b_rd_data_i,
    input  wire pwo_pkg::coeff_word_t  c_rd_data_i,
    output pwo_pkg::mem_req_t          a_rd_req_o,
    output pwo_pkg::mem_req_t          b_rd_req_o,
    output pwo_pkg::mem_req_t          c_rd_req_o,
    output pwo_pkg::mem_req_t          c_wr_req_o,
    output pwo_pkg::coeff_word_t       c_wr_data_o,
    output logic                       busy_o,
    output logic                       done_o
);

    pwo_pkg::pwo_cmd_t          cmd;
    logic                       data_valid;
    logic [`PWO_IDX_W-1:0]      data_idx;
    pwo_pkg::coeff_word_t       alu_res;
    logic                       alu_valid;
    logic [`PWO_IDX_W-1:0]      alu_idx;

    // Issue
    pwo_sequencer seq0 (
        .clk          (clk),
        .reset_n      (reset_n),
        .start_i      (start_i),
        .cmd_i        (cmd_i),
        .base_i       (base_i),
        .a_rd_req_o   (a_rd_req_o),
        .b_rd_req_o   (b_rd_req_o),
        .c_rd_req_o   (c_rd_req_o),
        .cmd_o        (cmd),
        .data_valid_o (data_valid),
        .data_idx_o   (data_idx),
        .busy_o       (busy_o),
        .done_o       (done_o)
    );

    // Execute stage uses c data only for pwm with accumulate
    pwo_lane_alu alu0 (
        .clk     (clk),
        .reset_n (reset_n),
        .cmd_i   (cmd),
        .valid_i (data_valid),
        .idx_i   (data_idx),
        .a_i     (a_rd_data_i),
        .b_i     (b_rd_data_i),
        .c_i     (c_rd_data_i),
        .res_o   (alu_res),
        .valid_o (alu_valid),
        .idx_o   (alu_idx)
    );

    // Result
    pwo_writeback wb0 (
        .base_c_i    (base_i.c),
        .valid_i     (alu_valid),
        .idx_i       (alu_idx),
        .res_i       (alu_res),
        .c_wr_req_o  (c_wr_req_o),
        .c_wr_data_o (c_wr_data_o)
    );

endmodule

`default_nettype wire

// ==== bench/pwo_assert.sv ====
// Protocol checks on the pointwise unit attached to pwo_top by the bind at the end
`timescale 1ns/1ns
`default_nettype none
`include "pwo_consts.svh"

module pwo_assert (
    input wire                     clk,
    input wire                     reset_n,
    input wire                     busy_i,
    input wire                     done_i,
    input wire pwo_pkg::mem_req_t  c_wr_req_i,
    input wire [`PWO_ADDR_W-1:0]   base_c_i
);

    // Failures seen so far
    int unsigned fail_cnt = 0;

    // Done is a single-cycle pulse
    done_pulse: assert property (@(posedge clk) disable iff (!reset_n)
        done_i |=> !done_i)
        else begin
            fail_cnt++;
            $error("done_o stayed high for more than one cycle");
        end

    // Writes only happen inside an operation
    wr_in_busy: assert property (@(posedge clk) disable iff (!reset_n)
        (c_wr_req_i.rd_wr_en == pwo_pkg::rw_write) |-> busy_i)
        else begin
            fail_cnt++;
            $error("write to c while busy_o is low");
        end

    // Write address stays inside the c polynomial, offset taken modulo the address space
    wr_in_range: assert property (@(posedge clk) disable iff (!reset_n)
        (c_wr_req_i.rd_wr_en == pwo_pkg::rw_write) |->
            (`PWO_ADDR_W'(c_wr_req_i.addr - base_c_i) < `PWO_WORDS))
        else begin
            fail_cnt++;
            $error("write address outside of polynomial c");
        end

endmodule

bind pwo_top pwo_assert pwo_assert0 (
    .clk        (clk),
    .reset_n    (reset_n),
    .busy_i     (busy_o),
    .done_i     (done_o),
    .c_wr_req_i (c_wr_req_o),
    .base_c_i   (base_i.c)
);

`default_nettype wire

// ==== bench/pwo_tb.sv ====
// Testbench running the pointwise test table against memory models of a, b and c
`timescale 1ns/1ns
`default_nettype none
`include "pwo_consts.svh"

module pwo_tb;

    localparam int CLK_PERIOD     = 4;
    localparam int NUM_TESTS      = 5;
    localparam int OP_CYCLES      = 66;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * 80 + 20;
    localparam logic [`PWO_COEFF_W-1:0] q_minus_1 = `PWO_Q - 23'd1;

    typedef struct {
        string             name;
        pwo_pkg::pwo_cmd_t cmd;
        logic              edge_ab;
    } test_entry_t;

    logic                  clk;
    logic                  reset_n;
    logic                  start;
    pwo_pkg::pwo_cmd_t     cmd;
    pwo_pkg::base_addr_t   base;
    pwo_pkg::coeff_word_t  a_rd_data;
    pwo_pkg::coeff_word_t  b_rd_data;
    pwo_pkg::coeff_word_t  c_rd_data;
    pwo_pkg::mem_req_t     a_rd_req;
    pwo_pkg::mem_req_t     b_rd_req;
    pwo_pkg::mem_req_t     c_rd_req;
    pwo_pkg::mem_req_t     c_wr_req;
    pwo_pkg::coeff_word_t  c_wr_data;
    logic                  busy;
    logic                  done;

    pwo_pkg::coeff_word_t  mem_a [`PWO_WORDS];
    pwo_pkg::coeff_word_t  mem_b [`PWO_WORDS];
    pwo_pkg::coeff_word_t  mem_c [`PWO_WORDS];
    pwo_pkg::coeff_word_t  c_orig [`PWO_WORDS];
    test_entry_t           tests [NUM_TESTS];
    logic [31:0]           rng_state;
    int                    cycle_cnt;
    int                    done_cnt;
    int                    c_rd_cnt;

    pwo_top dut0 (
        .clk         (clk),
        .reset_n     (reset_n),
        .start_i     (start),
        .cmd_i       (cmd),
        .base_i      (base),
        .a_rd_data_i (a_rd_data),
        .b_rd_data_i (b_rd_data),
        .c_rd_data_i (c_rd_data),
        .a_rd_req_o  (a_rd_req),
        .b_rd_req_o  (b_rd_req),
        .c_rd_req_o  (c_rd_req),
        .c_wr_req_o  (c_wr_req),
        .c_wr_data_o (c_wr_data),
        .busy_o      (busy),
        .done_o      (done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    // ====================
    // Memory models
    // ====================

    function automatic logic [`PWO_IDX_W-1:0] word_index(
        input logic [`PWO_ADDR_W-1:0] addr,
        input logic [`PWO_ADDR_W-1:0] base_addr
    );
        return `PWO_IDX_W'(addr - base_addr);
    endfunction

    // Read data comes one cycle after the request and writes land at the edge
    always @(posedge clk) begin
        if (a_rd_req.rd_wr_en == pwo_pkg::rw_read)
            a_rd_data <= mem_a[word_index(a_rd_req.addr, base.a)];
        if (b_rd_req.rd_wr_en == pwo_pkg::rw_read)
            b_rd_data <= mem_b[word_index(b_rd_req.addr, base.b)];
        if (c_rd_req.rd_wr_en == pwo_pkg::rw_read)
            c_rd_data <= mem_c[word_index(c_rd_req.addr, base.c)];
        if (c_wr_req.rd_wr_en == pwo_pkg::rw_write)
            mem_c[word_index(c_wr_req.addr, base.c)] <= c_wr_data;
    end

    // Done pulses and reads of c
    always @(negedge clk) begin
        if (done)
            done_cnt = done_cnt + 1;
        if (c_rd_req.rd_wr_en == pwo_pkg::rw_read)
            c_rd_cnt = c_rd_cnt + 1;
    end

    // ====================
    // Helpers
    // ====================

    function automatic logic [`PWO_COEFF_W-1:0] rand_coeff();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state[30:8] % `PWO_Q;
    endfunction

    function automatic logic [`PWO_COEFF_W-1:0] expected_lane(
        input pwo_pkg::pwo_cmd_t op,
        input longint unsigned   a,
        input longint unsigned   b,
        input longint unsigned   c
    );
        longint unsigned q;
        longint unsigned r;
        q = `PWO_Q;
        case (op.mode)
            pwo_pkg::pwm: r = op.accumulate ? (a * b + c) % q : (a * b) % q;
            pwo_pkg::pwa: r = (a + b) % q;
            default:      r = (a + q - b) % q;
        endcase
        return r[`PWO_COEFF_W-1:0];
    endfunction

    task automatic report_mismatch(
        input string        name,
        input string        what,
        input logic [95:0]  exp,
        input logic [95:0]  act
    );
        $display("FAILED %s %s expected %0h actual %0h", name, what, exp, act);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic fill_operands(input logic edge_ab);
        for (int w = 0; w < `PWO_WORDS; w++) begin
            for (int l = 0; l < `PWO_LANES; l++) begin
                mem_a[w][l] = {1'b0, edge_ab ? q_minus_1 : rand_coeff()};
                mem_b[w][l] = {1'b0, edge_ab ? q_minus_1 : rand_coeff()};
                mem_c[w][l] = {1'b0, rand_coeff()};
            end
            c_orig[w] = mem_c[w];
        end
    endtask

    task automatic run_test(input test_entry_t te);
        pwo_pkg::pwo_cmd_t    other;
        pwo_pkg::coeff_word_t exp_word;
        int                   start_cycle;
        int                   done_cycle;
        int                   exp_reads;
        fill_operands(te.edge_ab);
        other.mode       = (te.cmd.mode == pwo_pkg::pwa) ? pwo_pkg::pws : pwo_pkg::pwa;
        other.accumulate = 1'b1;
        exp_reads = (te.cmd.mode == pwo_pkg::pwm && te.cmd.accumulate) ? `PWO_WORDS : 0;
        done_cnt  = 0;
        c_rd_cnt  = 0;
        @(posedge clk);
        #1;
        start       = 1'b1;
        cmd         = te.cmd;
        start_cycle = cycle_cnt;
        @(posedge clk);
        #1;
        start = 1'b0;
        // Second start in the middle of the operation
        repeat (9) @(posedge clk);
        #1;
        start = 1'b1;
        cmd   = other;
        @(posedge clk);
        #1;
        start = 1'b0;
        cmd   = '0;
        @(negedge clk);
        while (!done) @(negedge clk);
        done_cycle = cycle_cnt;
        assert (done_cycle - start_cycle == OP_CYCLES)
            else report_mismatch(te.name, "cycles to done", OP_CYCLES, done_cycle - start_cycle);
        @(negedge clk);
        assert (busy == 1'b0) else report_mismatch(te.name, "busy after done", 0, busy);
        repeat (3) @(negedge clk);
        assert (done_cnt == 1) else report_mismatch(te.name, "done pulses", 1, done_cnt);
        assert (c_rd_cnt == exp_reads)
            else report_mismatch(te.name, "reads of c", exp_reads, c_rd_cnt);
        for (int w = 0; w < `PWO_WORDS; w++) begin
            for (int l = 0; l < `PWO_LANES; l++) begin
                exp_word[l].pad   = 1'b0;
                exp_word[l].coeff = expected_lane(te.cmd, mem_a[w][l].coeff,
                                                  mem_b[w][l].coeff, c_orig[w][l].coeff);
            end
            assert (mem_c[w] == exp_word)
                else report_mismatch(te.name, $sformatf("word %0d", w), exp_word, mem_c[w]);
        end
    endtask

    // ====================
    // Main sequence
    // ====================

    initial begin
        reset_n   = 1'b0;
        start     = 1'b0;
        cmd       = '0;
        base.a    = 15'h0123;
        base.b    = 15'h0456;
        base.c    = 15'h07c0;
        a_rd_data = '0;
        b_rd_data = '0;
        c_rd_data = '0;
        cycle_cnt = 0;
        done_cnt  = 0;
        c_rd_cnt  = 0;
        rng_state = 32'd24230;
        tests[0] = '{"pwm", '{pwo_pkg::pwm, 1'b0}, 1'b0};
        tests[1] = '{"pwm_acc", '{pwo_pkg::pwm, 1'b1}, 1'b0};
        tests[2] = '{"pwa", '{pwo_pkg::pwa, 1'b0}, 1'b0};
        tests[3] = '{"pws", '{pwo_pkg::pws, 1'b0}, 1'b0};
        tests[4] = '{"pwm_acc_edge", '{pwo_pkg::pwm, 1'b1}, 1'b1};
        repeat (5) @(posedge clk);
        #1;
        reset_n = 1'b1;
        @(negedge clk);
        assert (!busy && !done) else report_mismatch("reset", "busy and done", 0, {busy, done});
        assert (a_rd_req == '0 && b_rd_req == '0 && c_rd_req == '0 && c_wr_req == '0)
            else report_mismatch("reset", "requests", 0,
                                 {a_rd_req.rd_wr_en, b_rd_req.rd_wr_en,
                                  c_rd_req.rd_wr_en, c_wr_req.rd_wr_en});
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(tests[t]);
        end
        if (dut0.pwo_assert0.fail_cnt == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("Protocol assertions failed %0d times", dut0.pwo_assert0.fail_cnt);
            $display("Some tests failed");
            $fatal(1);
        end
    end

    // Watchdog
    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display("Some tests failed");
        $fatal(1);
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+design
design/pwo_pkg.sv
design/pwo_sequencer.sv
design/pwo_lane_alu.sv
design/pwo_writeback.sv
design/pwo_top.sv
bench/pwo_assert.sv
bench/pwo_tb.sv

// ==== Makefile ====
# Verilator build and run for the pointwise unit testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= pwo_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
